//--- hdl/dds_pkg.sv
package dds_pkg;

   // --------------------------------------------------
   // widths
   // --------------------------------------------------
   localparam int SAMPLE_W   = 12;
   localparam int PHASE_W    = 32;
   localparam int LUT_ADDR_W = 8;              // full sine cycle index
   localparam int QTR_ADDR_W = LUT_ADDR_W - 2; // one quadrant of the table
   localparam int LFSR_W     = 5;

   typedef logic signed [SAMPLE_W-1:0] sample_t;
   typedef logic [PHASE_W-1:0]         phase_t;

   // --------------------------------------------------
   // constants
   // --------------------------------------------------
   // about 3 Hz at a 50 MHz sample rate
   localparam phase_t PHASE_INC_BASE = 32'd258;

   localparam sample_t WAVE_CREST  = sample_t'(12'h7FF);
   localparam sample_t WAVE_MIDDLE = sample_t'(12'h000);
   localparam sample_t WAVE_TROUGH = sample_t'(12'h800);

   localparam logic [LFSR_W-1:0] LFSR_SEED = 5'b00001;

   // first sine quadrant, relative to the project root
   localparam string SINE_HEX_FILE = "hdl/sine_quarter.hex";

   // --------------------------------------------------
   // selector encodings and bundles
   // --------------------------------------------------
   typedef enum logic [1:0] {
      mod_ask  = 2'd0,
      mod_fsk  = 2'd1,
      mod_bpsk = 2'd2,
      mod_ook  = 2'd3
   } mod_mode_e;

   typedef enum logic [1:0] {
      sig_sin = 2'd0,
      sig_cos = 2'd1,
      sig_saw = 2'd2,
      sig_squ = 2'd3
   } sig_kind_e;

   typedef struct packed {
      mod_mode_e mod_mode;
      sig_kind_e sig_kind;
   } stage_ctrl_t;

   typedef struct packed {
      sample_t sin;
      sample_t cos;
      sample_t saw;
      sample_t squ;
   } wave_set_t;

endpackage

//--- hdl/control_decode.sv
`timescale 1ns/1ns

module control_decode import dds_pkg::*;
(
   input  logic [1:0]  modulation_sel,
   input  logic [1:0]  signal_sel,
   input  phase_t      fsk_phase_inc,
   output stage_ctrl_t stage_ctrl,
   output phase_t      phase_inc
);

   mod_mode_e mode;
   sig_kind_e kind;

   // --------------------------------------------------
   // selector decode
   // --------------------------------------------------
   always_comb
   begin
      mode = mod_mode_e'(modulation_sel);
      kind = sig_kind_e'(signal_sel);
   end

   always_comb
   begin
      stage_ctrl.mod_mode = mode;
      stage_ctrl.sig_kind = kind;
   end

   // only fsk moves the carrier frequency
   always_comb
   begin
      if (mode == mod_fsk)
      begin
         phase_inc = fsk_phase_inc;   // increment from outside
      end
      else
      begin
         phase_inc = PHASE_INC_BASE;
      end
   end

endmodule

//--- hdl/lfsr_gen.sv
`timescale 1ns/1ns

module lfsr_gen import dds_pkg::*;
(
   input  logic              sampler_sync,
   input  logic              reset_from_key,
   input  logic              lfsr_tick,
   output logic [LFSR_W-1:0] lfsr_state
);

   logic feedback;

   // taps for x^5 + x^3 + 1
   assign feedback = lfsr_state[4] ^ lfsr_state[2];

   // fibonacci form, shift left and feed bit 0
   always_ff @(posedge sampler_sync)
   begin
      if (reset_from_key)
      begin
         lfsr_state <= LFSR_SEED;
      end
      else if (lfsr_tick)
      begin
         lfsr_state <= {lfsr_state[LFSR_W-2:0], feedback};
      end
   end

endmodule

//--- hdl/dds_core.sv
`timescale 1ns/1ns

module dds_core import dds_pkg::*;
(
   input  logic      sampler_sync,
   input  logic      reset_from_key,
   input  phase_t    phase_inc,
   output wave_set_t waves
);

   sample_t                sine_rom [2**QTR_ADDR_W];
   phase_t                 phase;
   logic [LUT_ADDR_W-1:0]  lut_idx;
   logic [LUT_ADDR_W-1:0]  cos_idx;
   wave_set_t              next_waves;

   initial
   begin
      $readmemh(SINE_HEX_FILE, sine_rom);
   end

   // --------------------------------------------------
   // quarter-wave lookup
   // --------------------------------------------------
   // quadrant 1 and 3 walk the table backwards, 2 and 3 are negated
   function automatic sample_t sine_of(input logic [LUT_ADDR_W-1:0] idx);
      logic [QTR_ADDR_W-1:0] k;
      sample_t               entry;
      k = idx[QTR_ADDR_W-1:0];
      if (idx[LUT_ADDR_W-2])
      begin
         k = ~k;   // 63 - k
      end
      entry = sine_rom[k];
      return idx[LUT_ADDR_W-1] ? ~entry : entry;
   endfunction

   assign lut_idx = phase[PHASE_W-1 -: LUT_ADDR_W];

   // quarter cycle ahead
   assign cos_idx = {lut_idx[LUT_ADDR_W-1 -: 2] + 2'd1, lut_idx[QTR_ADDR_W-1:0]};

   always_comb
   begin
      next_waves.sin = sine_of(lut_idx);
      next_waves.cos = sine_of(cos_idx);
      next_waves.saw = sample_t'(phase[PHASE_W-1 -: SAMPLE_W]);   // top phase bits
      next_waves.squ = phase[PHASE_W-1] ? WAVE_TROUGH : WAVE_CREST;
   end

   // --------------------------------------------------
   // accumulator and output registers
   // --------------------------------------------------
   // waves take the phase held before this edge
   always_ff @(posedge sampler_sync)
   begin
      if (reset_from_key)
      begin
         phase <= '0;
         waves <= '0;
      end
      else
      begin
         phase <= phase + phase_inc;
         waves <= next_waves;
      end
   end

endmodule

//--- hdl/wave_select.sv
`timescale 1ns/1ns

module wave_select import dds_pkg::*;
(
   input  logic        sampler_sync,
   input  logic        reset_from_key,
   input  stage_ctrl_t stage_ctrl,
   input  wave_set_t   waves,
   input  logic        data_bit,
   output sample_t     modulated_out,
   output sample_t     signal_out
);

   sample_t mod_next;
   sample_t sig_next;

   // --------------------------------------------------
   // keying of the sine by the data bit
   // --------------------------------------------------
   always_comb
   begin
      unique case (stage_ctrl.mod_mode)
         mod_ask:  mod_next = data_bit ? waves.sin : WAVE_MIDDLE;
         mod_fsk:  mod_next = waves.sin;   // frequency already shifted upstream
         mod_bpsk: mod_next = data_bit ? waves.sin : ~waves.sin;
         mod_ook:  mod_next = data_bit ? WAVE_MIDDLE : WAVE_TROUGH;
      endcase
   end

   // raw waveform pick
   always_comb
   begin
      unique case (stage_ctrl.sig_kind)
         sig_sin: sig_next = waves.sin;
         sig_cos: sig_next = waves.cos;
         sig_saw: sig_next = waves.saw;
         sig_squ: sig_next = waves.squ;
      endcase
   end

   // --------------------------------------------------
   // output registers
   // --------------------------------------------------
   always_ff @(posedge sampler_sync)
   begin
      if (reset_from_key)
      begin
         modulated_out <= WAVE_MIDDLE;
         signal_out    <= WAVE_MIDDLE;
      end
      else
      begin
         modulated_out <= mod_next;
         signal_out    <= sig_next;
      end
   end

endmodule

//--- hdl/dds_modulator_top.sv
`timescale 1ns/1ns

module dds_modulator_top import dds_pkg::*;
(
   input  logic              sampler_sync,
   input  logic              reset_from_key,
   input  logic [1:0]        modulation_sel,
   input  logic [1:0]        signal_sel,
   input  phase_t            fsk_phase_inc,
   input  logic              lfsr_tick,
   output sample_t           modulated_out,
   output sample_t           signal_out,
   output logic [LFSR_W-1:0] lfsr_state
);

   stage_ctrl_t stage_ctrl;
   phase_t      phase_inc;
   wave_set_t   waves;

   // --------------------------------------------------
   // decode
   // --------------------------------------------------
   control_decode i_control_decode (
      .modulation_sel (modulation_sel),
      .signal_sel     (signal_sel),
      .fsk_phase_inc  (fsk_phase_inc),
      .stage_ctrl     (stage_ctrl),
      .phase_inc      (phase_inc)
   );

   // --------------------------------------------------
   // execute
   // --------------------------------------------------
   lfsr_gen i_lfsr_gen (
      .sampler_sync   (sampler_sync),
      .reset_from_key (reset_from_key),
      .lfsr_tick      (lfsr_tick),
      .lfsr_state     (lfsr_state)
   );

   dds_core i_dds_core (
      .sampler_sync   (sampler_sync),
      .reset_from_key (reset_from_key),
      .phase_inc      (phase_inc),
      .waves          (waves)
   );

   // result stage, keyed by the low lfsr bit
   wave_select i_wave_select (
      .sampler_sync   (sampler_sync),
      .reset_from_key (reset_from_key),
      .stage_ctrl     (stage_ctrl),
      .waves          (waves),
      .data_bit       (lfsr_state[0]),
      .modulated_out  (modulated_out),
      .signal_out     (signal_out)
   );

endmodule

//--- verif/dds_modulator_chk.sv
`timescale 1ns/1ns

module dds_modulator_chk import dds_pkg::*;
(
   input logic        sampler_sync,
   input logic        reset_from_key,
   input stage_ctrl_t stage_ctrl,
   input wave_set_t   waves,
   input sample_t     modulated_out,
   input sample_t     signal_out
);

   int fail_count = 0;   // failed assertions so far

   // both registers come out of reset at the zero level
   reset_to_middle : assert property (
      @(posedge sampler_sync) reset_from_key |=>
         (modulated_out == WAVE_MIDDLE && signal_out == WAVE_MIDDLE))
      else
      begin
         fail_count++;
         $error("outputs are not at the zero level after reset");
      end

   // on-off keying only knows two levels
   ook_two_levels : assert property (
      @(posedge sampler_sync) (!reset_from_key && stage_ctrl.mod_mode == mod_ook) |=>
         (modulated_out == WAVE_MIDDLE || modulated_out == WAVE_TROUGH))
      else
      begin
         fail_count++;
         $error("on-off keying produced a level other than middle or trough");
      end

   // fsk passes the sine through one register
   fsk_follows_sine : assert property (
      @(posedge sampler_sync) (!reset_from_key && stage_ctrl.mod_mode == mod_fsk) |=>
         (modulated_out == $past(waves.sin)))
      else
      begin
         fail_count++;
         $error("fsk output differs from the sine of the previous cycle");
      end

endmodule

bind wave_select dds_modulator_chk i_dds_modulator_chk (
   .sampler_sync   (sampler_sync),
   .reset_from_key (reset_from_key),
   .stage_ctrl     (stage_ctrl),
   .waves          (waves),
   .modulated_out  (modulated_out),
   .signal_out     (signal_out)
);

//--- verif/dds_modulator_tb.sv
`timescale 1ns/1ns

module dds_modulator_tb import dds_pkg::*;
();

   localparam int CLK_HALF        = 50;      // 100 ns period
   localparam int RESET_CYCLES    = 8;
   localparam int SEGMENTS        = 64;      // each mode 16 times
   localparam int BASE_RUN        = 9000;    // two saw steps at the base increment
   localparam int RELEASE_TIMEOUT = 20;      // cycles
   localparam int RUN_TIMEOUT     = 20000;   // cycles

   logic              sampler_sync;
   logic              reset_from_key;
   logic [1:0]        modulation_sel;
   logic [1:0]        signal_sel;
   phase_t            fsk_phase_inc;
   logic              lfsr_tick;
   sample_t           modulated_out;
   sample_t           signal_out;
   logic [LFSR_W-1:0] lfsr_state;

   logic [SAMPLE_W-1:0] sine_table [0:63];
   logic [31:0]         rng_state;
   logic                stim_done;

   // reference model state
   phase_t            m_phase;
   wave_set_t         m_waves;
   logic [LFSR_W-1:0] m_lfsr;
   sample_t           exp_mod;
   sample_t           exp_sig;

   int sample_errors = 0;
   int lfsr_errors   = 0;
   int assert_errors = 0;
   int timeouts      = 0;

   dds_modulator_top i_dds_modulator_top (
      .sampler_sync   (sampler_sync),
      .reset_from_key (reset_from_key),
      .modulation_sel (modulation_sel),
      .signal_sel     (signal_sel),
      .fsk_phase_inc  (fsk_phase_inc),
      .lfsr_tick      (lfsr_tick),
      .modulated_out  (modulated_out),
      .signal_out     (signal_out),
      .lfsr_state     (lfsr_state)
   );

   initial
   begin
      sampler_sync = 1'b0;
      $readmemh(SINE_HEX_FILE, sine_table);
   end

   always #CLK_HALF sampler_sync = ~sampler_sync;

   // --------------------------------------------------
   // random bits and reference functions
   // --------------------------------------------------
   function automatic logic [31:0] lfsr32_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];   // x^32 + x^22 + x^2 + x + 1
      return {s[30:0], fb};
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         rng_state = lfsr32_next(rng_state);
         v = {v[30:0], rng_state[0]};
      end
   endtask

   function automatic sample_t ref_sine(input logic [LUT_ADDR_W-1:0] idx);
      logic [5:0] k;
      logic [5:0] k_mirror;
      sample_t    s;
      k        = idx[5:0];
      k_mirror = 6'd63 - k;
      case (idx[7:6])
         2'd0:    s = sample_t'(sine_table[k]);
         2'd1:    s = sample_t'(sine_table[k_mirror]);
         2'd2:    s = sample_t'(~sine_table[k]);   // negative half
         default: s = sample_t'(~sine_table[k_mirror]);
      endcase
      return s;
   endfunction

   function automatic wave_set_t ref_waves(input phase_t phase);
      wave_set_t            w;
      logic [LUT_ADDR_W-1:0] idx;
      idx   = phase[31:24];
      w.sin = ref_sine(idx);
      w.cos = ref_sine(idx + 8'd64);   // quarter turn ahead
      w.saw = sample_t'(phase[31:20]);
      w.squ = (phase[31] == 1'b0) ? WAVE_CREST : WAVE_TROUGH;
      return w;
   endfunction

   function automatic sample_t ref_signal(input sig_kind_e kind, input wave_set_t w);
      sample_t s;
      case (kind)
         sig_sin: s = w.sin;
         sig_cos: s = w.cos;
         sig_saw: s = w.saw;
         default: s = w.squ;
      endcase
      return s;
   endfunction

   function automatic sample_t ref_modulated(input mod_mode_e mode, input sample_t sine,
                                             input logic bit_in);
      sample_t s;
      case (mode)
         mod_ask:  s = bit_in ? sine : WAVE_MIDDLE;
         mod_fsk:  s = sine;
         mod_bpsk: s = bit_in ? sine : ~sine;   // phase flip on a zero
         default:  s = bit_in ? WAVE_MIDDLE : WAVE_TROUGH;
      endcase
      return s;
   endfunction

   function automatic phase_t ref_increment(input mod_mode_e mode, input phase_t fsk_inc);
      return (mode == mod_fsk) ? fsk_inc : PHASE_INC_BASE;
   endfunction

   function automatic logic [LFSR_W-1:0] ref_lfsr_step(input logic [LFSR_W-1:0] s);
      return {s[3:0], s[4] ^ s[2]};   // x^5 + x^3 + 1
   endfunction

   // --------------------------------------------------
   // model, two edges from phase to output
   // --------------------------------------------------
   always @(posedge sampler_sync)
   begin : model_step
      mod_mode_e mode;
      sig_kind_e kind;
      mode = mod_mode_e'(modulation_sel);
      kind = sig_kind_e'(signal_sel);
      if (reset_from_key)
      begin
         m_phase = '0;
         m_waves = '0;
         m_lfsr  = LFSR_SEED;
         exp_mod = WAVE_MIDDLE;
         exp_sig = WAVE_MIDDLE;
      end
      else
      begin
         // outputs use last cycle's waves and the bit before this step
         exp_mod = ref_modulated(mode, m_waves.sin, m_lfsr[0]);
         exp_sig = ref_signal(kind, m_waves);
         m_waves = ref_waves(m_phase);
         m_phase = m_phase + ref_increment(mode, fsk_phase_inc);
         if (lfsr_tick)
         begin
            m_lfsr = ref_lfsr_step(m_lfsr);
         end
      end
   end

   task automatic check_sample(input string what, input sample_t got, input sample_t expected);
      if (got !== expected)
      begin
         sample_errors++;
         $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
      end
   endtask

   task automatic check_lfsr(input logic [LFSR_W-1:0] got, input logic [LFSR_W-1:0] expected);
      if (got !== expected)
      begin
         lfsr_errors++;
         $display("Error at %0t ns: lfsr_state is %b, expected %b", $time, got, expected);
      end
   endtask

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------
   initial
   begin : drive_stimulus
      logic [31:0] r;
      int          seg_len;
      rng_state      = 32'heaa2_0d83;
      stim_done      = 1'b0;
      reset_from_key = 1'b1;
      modulation_sel = 2'd0;
      signal_sel     = 2'd0;
      fsk_phase_inc  = '0;
      lfsr_tick      = 1'b0;
      repeat (RESET_CYCLES) @(posedge sampler_sync);
      #1;
      reset_from_key = 1'b0;
      repeat (6) @(posedge sampler_sync);   // seed must hold without ticks
      #1;
      for (int seg = 0; seg < SEGMENTS; seg++)
      begin
         draw_bits(5, r);
         seg_len        = 16 + int'(r[4:0]);
         modulation_sel = seg[1:0];   // fsk segments scatter the phase
         draw_bits(32, r);
         fsk_phase_inc  = r;
         for (int c = 0; c < seg_len; c++)
         begin
            draw_bits(2, r);
            signal_sel = r[1:0];
            draw_bits(1, r);
            lfsr_tick  = r[0];
            @(posedge sampler_sync);
            #1;
         end
      end
      // long ask stretch, the saw only moves every 4064 cycles at the base step
      modulation_sel = 2'd0;
      for (int c = 0; c < BASE_RUN; c++)
      begin
         draw_bits(2, r);
         signal_sel = r[1:0];
         draw_bits(1, r);
         lfsr_tick  = r[0];
         @(posedge sampler_sync);
         #1;
      end
      lfsr_tick = 1'b0;
      repeat (4) @(posedge sampler_sync);
      #1;
      stim_done = 1'b1;
   end

   // --------------------------------------------------
   // compare at the falling edge and report
   // --------------------------------------------------
   initial
   begin : compare_and_report
      int wait_cycles;
      int run_cycles;
      wait_cycles = 0;
      run_cycles  = 0;
      while (reset_from_key !== 1'b0 && wait_cycles < RELEASE_TIMEOUT)
      begin
         @(negedge sampler_sync);
         wait_cycles++;
      end
      if (reset_from_key !== 1'b0)
      begin
         $display("timeout: reset was never released");
         $display("TEST FAILED");
         $finish;
      end
      else
      begin
         while (!stim_done && run_cycles < RUN_TIMEOUT)
         begin
            check_sample("modulated_out", modulated_out, exp_mod);
            check_sample("signal_out", signal_out, exp_sig);
            check_lfsr(lfsr_state, m_lfsr);
            run_cycles++;
            @(negedge sampler_sync);
         end
         if (!stim_done)
         begin
            timeouts++;
            $display("timeout: stimulus did not finish in %0d cycles", RUN_TIMEOUT);
         end
         assert_errors = i_dds_modulator_top.i_wave_select.i_dds_modulator_chk.fail_count;
         $display("errors: %0d sample, %0d lfsr, %0d assertion, %0d timeout, over %0d cycles",
                  sample_errors, lfsr_errors, assert_errors, timeouts, run_cycles);
         if (sample_errors == 0 && lfsr_errors == 0 && assert_errors == 0 && timeouts == 0)
         begin
            $display("TEST PASSED");
         end
         else
         begin
            $display("TEST FAILED");
         end
         $finish;
      end
   end

endmodule

//--- hdl/sine_quarter.hex
// one hex column: round(2047 * sin(2*pi*(k+0.5)/256)), k = 0 to 63
019
04B
07E
0B0
0E2
113
145
177
1A8
1D9
20A
23A
26A
29A
2C9
2F8
327
354
382
3AF
3DB
407
432
45C
486
4AF
4D7
4FF
526
54C
571
596
5B9
5DC
5FD
61E
63E
65D
67B
698
6B4
6CF
6E9
701
719
730
745
759
76D
77F
790
79F
7AE
7BB
7C8
7D3
7DC
7E5
7EC
7F3
7F7
7FB
7FE
7FF

//--- vlog.f
hdl/dds_pkg.sv
hdl/control_decode.sv
hdl/lfsr_gen.sv
hdl/dds_core.sv
hdl/wave_select.sv
hdl/dds_modulator_top.sv
verif/dds_modulator_chk.sv
verif/dds_modulator_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the design and testbench with verilator, run, and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module dds_modulator_tb -f vlog.f -o dds_sim \
   || { echo "verilator build failed"; exit 1; }
sim_output=$(./obj_dir/dds_sim)
echo "$sim_output"
echo "$sim_output" | grep -q "TEST PASSED" && echo "run_sim: passed" \
   || { echo "run_sim: failed"; exit 1; }
